// ==== hw/lsq_pkg.sv ====
`default_nettype none

package lsq_pkg;

  // Entries in each of the two queues
  localparam int LSQ_DEPTH = 8;
  localparam int IDX_W     = $clog2(LSQ_DEPTH);

  // Word addresses and data words
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // Slot within a queue
  typedef logic [IDX_W-1:0] idx_t;

  // Slot plus wrap bit, for full/empty and age distance
  typedef logic [IDX_W:0] ptr_t;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

// ==== hw/forward_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface forward_if import lsq_pkg::*; ();

  // Load side request
  addr_t req_addr;
  ptr_t  req_limit;

  // Store side answer, same cycle
  logic  hit;
  data_t data;

  modport requester (
    output req_addr,
    output req_limit,
    input  hit,
    input  data
  );

  modport responder (
    input  req_addr,
    input  req_limit,
    output hit,
    output data
  );

endinterface

`default_nettype wire

// ==== hw/queue_ptrs.sv ====
`timescale 1ns/1ns
`default_nettype none

module queue_ptrs import lsq_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic alloc,
  input  logic dealloc,
  output ptr_t head,
  output ptr_t tail,
  output logic full,
  output logic empty
);

  idx_t head_idx;
  idx_t tail_idx;

  assign head_idx = head[IDX_W-1:0];
  assign tail_idx = tail[IDX_W-1:0];

  // Same slot, opposite lap means every entry is taken
  assign full  = (head_idx == tail_idx) && (head[IDX_W] != tail[IDX_W]);
  assign empty = (head == tail);

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + ptr_t'(1);
      end
      if (dealloc) begin
        head <= head + ptr_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/store_forward.sv ====
`timescale 1ns/1ns
`default_nettype none

module store_forward import lsq_pkg::*; (
  input  ptr_t  head,
  input  ptr_t  limit,
  input  addr_t entry_addr [LSQ_DEPTH],
  input  data_t entry_data [LSQ_DEPTH],
  input  logic  entry_done [LSQ_DEPTH],
  input  addr_t addr,
  output logic  hit,
  output data_t data
);

  ptr_t older;
  ptr_t span;

  // Stores between head and the load's snapshot are older than the load
  assign older = limit - head;

  // Head already past the snapshot, so every older store has committed
  assign span = (older > ptr_t'(LSQ_DEPTH)) ? '0 : older;

  // Walk from the youngest older store back toward head
  always_comb begin
    idx_t slot;
    hit  = 1'b0;
    data = '0;
    for (int k = 0; k < LSQ_DEPTH; k++) begin
      slot = limit[IDX_W-1:0] - idx_t'(k + 1);
      if (!hit && (ptr_t'(k) < span) && entry_done[slot] &&
          (entry_addr[slot] == addr)) begin
        hit  = 1'b1;
        data = entry_data[slot];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/store_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module store_queue import lsq_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         alloc,
  input  logic         st_exec_valid,
  input  idx_t         st_exec_idx,
  input  addr_t        st_exec_addr,
  input  data_t        st_exec_data,
  input  logic         retire_store,
  output logic         full,
  output ptr_t         sq_tail,
  output logic         mem_wr_en,
  output addr_t        mem_wr_addr,
  output data_t        mem_wr_data,
  forward_if.responder fwd
);

  addr_t st_addr [LSQ_DEPTH];
  data_t st_data [LSQ_DEPTH];
  logic  st_done [LSQ_DEPTH];

  ptr_t  head;
  logic  empty;
  logic  head_release;
  idx_t  head_idx;
  idx_t  tail_idx;

  assign head_idx = head[IDX_W-1:0];
  assign tail_idx = sq_tail[IDX_W-1:0];

  assign head_release = retire_store & ~empty;

  queue_ptrs u_ptrs (
    .clock   (clock),
    .reset   (reset),
    .alloc   (alloc),
    .dealloc (head_release),
    .head    (head),
    .tail    (sq_tail),
    .full    (full),
    .empty   (empty)
  );

  // Executed flags
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < LSQ_DEPTH; i++) begin
        st_done[i] <= 1'b0;
      end
    end else begin
      if (alloc) begin
        st_done[tail_idx] <= 1'b0;
      end
      if (st_exec_valid) begin
        st_done[st_exec_idx] <= 1'b1;
      end
    end
  end

  // Address and data fill at execute
  always_ff @(posedge clock) begin
    if (st_exec_valid) begin
      st_addr[st_exec_idx] <= st_exec_addr;
      st_data[st_exec_idx] <= st_exec_data;
    end
  end

  // Oldest store goes to memory on commit
  assign mem_wr_en   = head_release;
  assign mem_wr_addr = st_addr[head_idx];
  assign mem_wr_data = st_data[head_idx];

  store_forward u_fwd (
    .head       (head),
    .limit      (fwd.req_limit),
    .entry_addr (st_addr),
    .entry_data (st_data),
    .entry_done (st_done),
    .addr       (fwd.req_addr),
    .hit        (fwd.hit),
    .data       (fwd.data)
  );

endmodule

`default_nettype wire

// ==== hw/load_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_queue import lsq_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         alloc,
  input  ptr_t         sq_tail,
  input  logic         ld_exec_valid,
  input  idx_t         ld_exec_idx,
  input  addr_t        ld_exec_addr,
  input  data_t        mem_rd_data,
  input  logic         retire_load,
  output logic         full,
  output ptr_t         lq_tail,
  output logic         mem_rd_en,
  output addr_t        mem_rd_addr,
  output logic         ld_done_valid,
  output idx_t         ld_done_idx,
  output data_t        ld_done_data,
  output logic         ld_done_forwarded,
  forward_if.requester fwd
);

  // Store queue tail seen at dispatch, marks where younger stores begin
  ptr_t  lq_snap [LSQ_DEPTH];
  logic  lq_done [LSQ_DEPTH];

  ptr_t  head;
  logic  empty;
  logic  head_release;
  idx_t  head_idx;
  idx_t  tail_idx;

  assign head_idx = head[IDX_W-1:0];
  assign tail_idx = lq_tail[IDX_W-1:0];

  // Head leaves only once its result has been produced
  assign head_release = retire_load & ~empty & lq_done[head_idx];

  queue_ptrs u_ptrs (
    .clock   (clock),
    .reset   (reset),
    .alloc   (alloc),
    .dealloc (head_release),
    .head    (head),
    .tail    (lq_tail),
    .full    (full),
    .empty   (empty)
  );

  always_ff @(posedge clock) begin
    if (alloc) begin
      lq_snap[tail_idx] <= sq_tail;
    end
  end

  // Forward request to the store queue
  assign fwd.req_addr  = ld_exec_addr;
  assign fwd.req_limit = lq_snap[ld_exec_idx];

  // Memory only on a forward miss
  assign mem_rd_en   = ld_exec_valid & ~fwd.hit;
  assign mem_rd_addr = ld_exec_addr;

  always_ff @(posedge clock) begin
    if (reset) begin
      ld_done_valid <= 1'b0;
      for (int i = 0; i < LSQ_DEPTH; i++) begin
        lq_done[i] <= 1'b0;
      end
    end else begin
      ld_done_valid <= ld_exec_valid;
      if (alloc) begin
        lq_done[tail_idx] <= 1'b0;
      end
      if (ld_exec_valid) begin
        lq_done[ld_exec_idx] <= 1'b1;
      end
    end
  end

  // Result register, one cycle after execute
  always_ff @(posedge clock) begin
    if (ld_exec_valid) begin
      ld_done_idx       <= ld_exec_idx;
      ld_done_data      <= fwd.hit ? fwd.data : mem_rd_data;
      ld_done_forwarded <= fwd.hit;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsq.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsq import lsq_pkg::*; (
  input  logic  clock,
  input  logic  reset,

  input  logic  dispatch_valid,
  input  logic  dispatch_is_store,
  output logic  dispatch_ready,
  output idx_t  dispatch_idx,

  input  logic  st_exec_valid,
  input  idx_t  st_exec_idx,
  input  addr_t st_exec_addr,
  input  data_t st_exec_data,

  input  logic  ld_exec_valid,
  input  idx_t  ld_exec_idx,
  input  addr_t ld_exec_addr,

  output logic  ld_done_valid,
  output idx_t  ld_done_idx,
  output data_t ld_done_data,
  output logic  ld_done_forwarded,

  output logic  mem_rd_en,
  output addr_t mem_rd_addr,
  input  data_t mem_rd_data,

  output logic  mem_wr_en,
  output addr_t mem_wr_addr,
  output data_t mem_wr_data,

  input  logic  retire_store,
  input  logic  retire_load
);

  logic sq_full;
  logic lq_full;
  logic sq_alloc;
  logic lq_alloc;
  ptr_t sq_tail;
  ptr_t lq_tail;

  forward_if fwd_bus ();

  // Either queue full holds off all dispatch
  assign dispatch_ready = ~(sq_full | lq_full);

  assign sq_alloc = dispatch_valid & dispatch_ready & dispatch_is_store;
  assign lq_alloc = dispatch_valid & dispatch_ready & ~dispatch_is_store;

  assign dispatch_idx = dispatch_is_store ? sq_tail[IDX_W-1:0] : lq_tail[IDX_W-1:0];

  store_queue u_sq (
    .clock         (clock),
    .reset         (reset),
    .alloc         (sq_alloc),
    .st_exec_valid (st_exec_valid),
    .st_exec_idx   (st_exec_idx),
    .st_exec_addr  (st_exec_addr),
    .st_exec_data  (st_exec_data),
    .retire_store  (retire_store),
    .full          (sq_full),
    .sq_tail       (sq_tail),
    .mem_wr_en     (mem_wr_en),
    .mem_wr_addr   (mem_wr_addr),
    .mem_wr_data   (mem_wr_data),
    .fwd           (fwd_bus.responder)
  );

  load_queue u_lq (
    .clock             (clock),
    .reset             (reset),
    .alloc             (lq_alloc),
    .sq_tail           (sq_tail),
    .ld_exec_valid     (ld_exec_valid),
    .ld_exec_idx       (ld_exec_idx),
    .ld_exec_addr      (ld_exec_addr),
    .mem_rd_data       (mem_rd_data),
    .retire_load       (retire_load),
    .full              (lq_full),
    .lq_tail           (lq_tail),
    .mem_rd_en         (mem_rd_en),
    .mem_rd_addr       (mem_rd_addr),
    .ld_done_valid     (ld_done_valid),
    .ld_done_idx       (ld_done_idx),
    .ld_done_data      (ld_done_data),
    .ld_done_forwarded (ld_done_forwarded),
    .fwd               (fwd_bus.requester)
  );

endmodule

`default_nettype wire

// ==== verif/lsq_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsq_properties import lsq_pkg::*; (
  input wire logic clock,
  input wire logic reset,
  input wire logic retire_store,
  input wire logic retire_load,
  input wire logic mem_wr_en,
  input wire logic mem_rd_en,
  input wire logic ld_done_valid,
  input wire logic sq_empty,
  input wire logic sq_head_done,
  input wire logic lq_empty,
  input wire logic lq_head_done
);

  // Commit needs an executed head store
  assert property (@(posedge clock) disable iff (reset)
    retire_store |-> !sq_empty && sq_head_done)
    else $error("store retired while head not ready");

  assert property (@(posedge clock) disable iff (reset)
    retire_load |-> !lq_empty && lq_head_done)
    else $error("load retired while head not ready");

  // First cycle out of reset is quiet
  assert property (@(posedge clock) $fell(reset) |-> !mem_rd_en && !ld_done_valid)
    else $error("outputs active right after reset");

  assert property (@(posedge clock) mem_wr_en == retire_store)
    else $error("mem_wr_en differs from retire_store");

endmodule

bind lsq lsq_properties props_i (
  .clock         (clock),
  .reset         (reset),
  .retire_store  (retire_store),
  .retire_load   (retire_load),
  .mem_wr_en     (mem_wr_en),
  .mem_rd_en     (mem_rd_en),
  .ld_done_valid (ld_done_valid),
  .sq_empty      (u_sq.empty),
  .sq_head_done  (u_sq.st_done[u_sq.head_idx]),
  .lq_empty      (u_lq.empty),
  .lq_head_done  (u_lq.lq_done[u_lq.head_idx])
);

`default_nettype wire

// ==== verif/lsq_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

  localparam int NUM_OPS    = 4000;
  localparam int WAIT_LIMIT = 8;

  logic  clock;
  logic  reset;
  logic  dispatch_valid;
  logic  dispatch_is_store;
  logic  dispatch_ready;
  idx_t  dispatch_idx;
  logic  st_exec_valid;
  idx_t  st_exec_idx;
  addr_t st_exec_addr;
  data_t st_exec_data;
  logic  ld_exec_valid;
  idx_t  ld_exec_idx;
  addr_t ld_exec_addr;
  logic  ld_done_valid;
  idx_t  ld_done_idx;
  data_t ld_done_data;
  logic  ld_done_forwarded;
  logic  mem_rd_en;
  addr_t mem_rd_addr;
  data_t mem_rd_data;
  logic  mem_wr_en;
  addr_t mem_wr_addr;
  data_t mem_wr_data;
  logic  retire_store;
  logic  retire_load;

  data_t mem_words [0:(1<<ADDR_W)-1];

  // Queue model with index 0 as the oldest entry
  addr_t m_st_addr [$];
  data_t m_st_data [$];
  logic  m_st_done [$];
  int    m_ld_snap [$];
  logic  m_ld_done [$];
  int    st_head_count;
  int    st_tail_count;
  int    ld_head_count;
  int    ld_tail_count;
  int    fwd_count;
  int    mem_count;
  int    commit_count;

  lsq dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Memory answers in the same cycle and writes at the edge
  assign mem_rd_data = mem_words[mem_rd_addr];

  always @(posedge clock) begin
    if (mem_wr_en) begin
      mem_words[mem_wr_addr] <= mem_wr_data;
    end
  end

  initial begin
    #(20 * (NUM_OPS * 4 + 200));
    $display("Simulation ran past its time limit");
    report_failure();
  end

  task automatic report_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic compare_data(string what, data_t got, data_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic compare_addr(string what, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic compare_idx(string what, idx_t got, idx_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic compare_bit(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic drive_idle();
    dispatch_valid    <= 1'b0;
    dispatch_is_store <= 1'b0;
    st_exec_valid     <= 1'b0;
    ld_exec_valid     <= 1'b0;
    retire_store      <= 1'b0;
    retire_load       <= 1'b0;
  endtask

  // Youngest older executed store still queued or else memory
  function automatic logic expect_load(input addr_t a, input int snap, output data_t d);
    int p;
    for (int j = snap - 1; j >= st_head_count; j--) begin
      p = j - st_head_count;
      if (m_st_done[p] && m_st_addr[p] == a) begin
        d = m_st_data[p];
        return 1'b1;
      end
    end
    d = mem_words[a];
    return 1'b0;
  endfunction

  task automatic await_load_result();
    int waited;
    waited = 0;
    do begin
      @(posedge clock);
      drive_idle();
      @(negedge clock);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Load result did not arrive within %0d cycles", WAIT_LIMIT);
        report_failure();
      end
    end while (!ld_done_valid);
    if (waited != 1) begin
      $display("FAIL %0t: load result after %0d cycles, expected 1", $time, waited);
      report_failure();
    end
  endtask

  initial begin
    int    kind;
    int    pos;
    int    pick[$];
    logic  is_st;
    logic  exp_ready;
    logic  exp_fwd;
    data_t exp_data;
    addr_t a;
    data_t d;

    void'($urandom(32'h3ee8_6878));
    reset             = 1'b1;
    dispatch_valid    = 1'b0;
    dispatch_is_store = 1'b0;
    st_exec_valid     = 1'b0;
    st_exec_idx       = '0;
    st_exec_addr      = '0;
    st_exec_data      = '0;
    ld_exec_valid     = 1'b0;
    ld_exec_idx       = '0;
    ld_exec_addr      = '0;
    retire_store      = 1'b0;
    retire_load       = 1'b0;
    st_head_count = 0;
    st_tail_count = 0;
    ld_head_count = 0;
    ld_tail_count = 0;
    fwd_count     = 0;
    mem_count     = 0;
    commit_count  = 0;
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      mem_words[i] = {addr_t'(i) ^ 16'hc3a5, addr_t'(i)};
    end

    repeat (10) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    compare_bit("dispatch_ready after reset", dispatch_ready, 1'b1);
    compare_bit("ld_done_valid after reset", ld_done_valid, 1'b0);
    compare_bit("mem_rd_en after reset", mem_rd_en, 1'b0);
    compare_bit("mem_wr_en after reset", mem_wr_en, 1'b0);

    for (int op = 0; op < NUM_OPS; op++) begin
      @(posedge clock);
      drive_idle();
      kind = $urandom_range(0, 3);
      is_st = $urandom_range(0, 1) == 1;
      pick.delete();
      pos = -1;
      a = addr_t'(16'h0040 + $urandom_range(0, 3));
      d = $urandom;
      if (kind == 0) begin
        dispatch_valid    <= 1'b1;
        dispatch_is_store <= is_st;
      end else if (kind == 1 || kind == 2) begin
        if (kind == 1) begin
          foreach (m_st_done[i]) begin
            if (!m_st_done[i]) begin
              pick.push_back(i);
            end
          end
        end else begin
          foreach (m_ld_done[i]) begin
            if (!m_ld_done[i]) begin
              pick.push_back(i);
            end
          end
        end
        if (pick.size() > 0) begin
          pos = pick[$urandom_range(0, pick.size() - 1)];
        end
        if (pos >= 0 && kind == 1) begin
          st_exec_valid <= 1'b1;
          st_exec_idx   <= idx_t'(st_head_count + pos);
          st_exec_addr  <= a;
          st_exec_data  <= d;
        end else if (pos >= 0) begin
          ld_exec_valid <= 1'b1;
          ld_exec_idx   <= idx_t'(ld_head_count + pos);
          ld_exec_addr  <= a;
        end
      end else if (is_st && m_st_done.size() > 0 && m_st_done[0]) begin
        retire_store <= 1'b1;
        pos = 0;
      end else if (!is_st && m_ld_done.size() > 0 && m_ld_done[0]) begin
        retire_load <= 1'b1;
        pos = 0;
      end

      @(negedge clock);
      compare_bit("mem_wr_en", mem_wr_en, kind == 3 && is_st && pos == 0);
      // Result pulse of the previous load is already over
      compare_bit("ld_done_valid", ld_done_valid, 1'b0);
      if (kind == 0) begin
        // Back-pressure as soon as either queue holds LSQ_DEPTH entries
        exp_ready = (m_st_done.size() < LSQ_DEPTH) && (m_ld_done.size() < LSQ_DEPTH);
        compare_bit("dispatch_ready", dispatch_ready, exp_ready);
        compare_idx("dispatch_idx", dispatch_idx,
                    idx_t'(is_st ? st_tail_count : ld_tail_count));
        if (exp_ready && is_st) begin
          m_st_addr.push_back('0);
          m_st_data.push_back('0);
          m_st_done.push_back(1'b0);
          st_tail_count++;
        end else if (exp_ready) begin
          m_ld_snap.push_back(st_tail_count);
          m_ld_done.push_back(1'b0);
          ld_tail_count++;
        end
      end else if (kind == 1 && pos >= 0) begin
        m_st_addr[pos] = a;
        m_st_data[pos] = d;
        m_st_done[pos] = 1'b1;
      end else if (kind == 2 && pos >= 0) begin
        exp_fwd = expect_load(a, m_ld_snap[pos], exp_data);
        compare_bit("mem_rd_en", mem_rd_en, !exp_fwd);
        if (!exp_fwd) begin
          compare_addr("mem_rd_addr", mem_rd_addr, a);
        end
        m_ld_done[pos] = 1'b1;
        await_load_result();
        compare_idx("ld_done_idx", ld_done_idx, idx_t'(ld_head_count + pos));
        compare_data("ld_done_data", ld_done_data, exp_data);
        compare_bit("ld_done_forwarded", ld_done_forwarded, exp_fwd);
        if (exp_fwd) fwd_count++;
        else mem_count++;
      end else if (kind == 3 && is_st && pos == 0) begin
        compare_addr("mem_wr_addr", mem_wr_addr, m_st_addr[0]);
        compare_data("mem_wr_data", mem_wr_data, m_st_data[0]);
        void'(m_st_addr.pop_front());
        void'(m_st_data.pop_front());
        void'(m_st_done.pop_front());
        st_head_count++;
        commit_count++;
      end else if (kind == 3 && pos == 0) begin
        void'(m_ld_snap.pop_front());
        void'(m_ld_done.pop_front());
        ld_head_count++;
      end
    end

    if (fwd_count == 0 || mem_count == 0 || commit_count == 0) begin
      $display("Random run missed forwarding, memory reads or commits");
      report_failure();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
hw/lsq_pkg.sv
hw/forward_if.sv
hw/queue_ptrs.sv
hw/store_forward.sv
hw/store_queue.sv
hw/load_queue.sv
hw/lsq.sv
verif/lsq_properties.sv
verif/lsq_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LSQ testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module lsq_tb -o lsq_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/lsq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Everything OK" sim.log; then
  exit 0
fi
exit 1
